// File: design/sfp_ctrl_config.svh
`ifndef SFP_CTRL_CONFIG_SVH
`define SFP_CTRL_CONFIG_SVH

// transceiver lanes in the quad
`define SFP_NLANES 2

// management bus, byte addressed
`define SFP_ADR_W 14
`define SFP_DAT_W 32
`define SFP_SEL_W (`SFP_DAT_W/8)

// address decode: region bit splits control space (0) from DRP space (1)
`define SFP_REGION_BIT 13
`define SFP_LANE_BIT 2
`define DRP_LANE_BIT 12

// DRP port, address comes from byte address bits 11:2
`define DRP_ADR_W 10
`define DRP_ADR_LSB 2
`define DRP_DAT_W 16

// dmonitor half per lane, and synchronizer depth
`define SFP_DMON_W 16
`define SYNC_STAGES 2

`endif

// File: design/sfp_bus_pkg.sv
`include "sfp_ctrl_config.svh"

package sfp_bus_pkg;

    // one Wishbone request as seen by a slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`SFP_ADR_W-1:0] adr;
        logic [`SFP_SEL_W-1:0] sel;
        logic [`SFP_DAT_W-1:0] dat;
    } wb_req_t;

    // slave response, dat is only meaningful while ack is high
    typedef struct packed {
        logic                  ack;
        logic [`SFP_DAT_W-1:0] dat;
    } wb_rsp_t;

    // receive-side flags of one lane
    typedef struct packed {
        logic block_lock;
        logic high_ber;
    } lane_status_t;

    // per-lane transceiver controls
    typedef struct packed {
        logic       eye_rst;
        // GT loopback encoding, 000 is normal operation
        logic [2:0] loopback;
    } lane_ctrl_t;

endpackage

// File: design/drp_pkg.sv
`include "sfp_ctrl_config.svh"

package drp_pkg;

    // command shared by both lanes; only the enable is per lane
    typedef struct packed {
        logic                  we;
        logic [`DRP_ADR_W-1:0] addr;
        logic [`DRP_DAT_W-1:0] di;
    } drp_cmd_t;

    // bridge sequencing
    typedef enum logic [1:0] {
        // waiting for a DRP-space strobe
        DRP_IDLE = 2'd0,
        // enable issued, waiting for the lane's ready
        DRP_WAIT = 2'd1,
        // one cycle of bus ack
        DRP_ACK  = 2'd2
    } drp_state_e;

endpackage

// File: design/lane_status_sync.sv
`timescale 1ns/1ps
`include "sfp_ctrl_config.svh"

module lane_status_sync (
    input  logic                                      wb_clk_i,
    input  logic                                      reset_i,
    input  logic                                      qpll_lock_i,
    input  sfp_bus_pkg::lane_status_t [`SFP_NLANES-1:0] lane_status_i,
    output logic                                      qpll_lock_o,
    output sfp_bus_pkg::lane_status_t [`SFP_NLANES-1:0] lane_status_o
);
    import sfp_bus_pkg::*;

    // stage 0 is the metastable capture flop
    logic [`SYNC_STAGES-1:0]                       qpll_sync_q;
    lane_status_t [`SYNC_STAGES-1:0][`SFP_NLANES-1:0] lane_sync_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            qpll_sync_q <= '0;
            lane_sync_q <= '0;
        end else begin
            qpll_sync_q <= {qpll_sync_q[`SYNC_STAGES-2:0], qpll_lock_i};
            lane_sync_q <= {lane_sync_q[`SYNC_STAGES-2:0], lane_status_i};
        end
    end

    // last stage is safe to use in the wb_clk_i domain
    assign qpll_lock_o   = qpll_sync_q[`SYNC_STAGES-1];
    assign lane_status_o = lane_sync_q[`SYNC_STAGES-1];

endmodule

// File: design/gt_ctrl_regs.sv
`timescale 1ns/1ps
`include "sfp_ctrl_config.svh"

module gt_ctrl_regs (
    input  logic                                      wb_clk_i,
    input  logic                                      reset_i,
    input  sfp_bus_pkg::wb_req_t                      req_i,
    output sfp_bus_pkg::wb_rsp_t                      rsp_o,
    input  logic                                      qpll_lock_i,
    input  sfp_bus_pkg::lane_status_t [`SFP_NLANES-1:0] lane_status_i,
    input  logic [`SFP_NLANES*`SFP_DMON_W-1:0]        dmonitor_i,
    output logic                                      gbe_rst_o,
    output sfp_bus_pkg::lane_ctrl_t [`SFP_NLANES-1:0]   lane_ctrl_o
);
    import sfp_bus_pkg::*;

    logic                            gbe_rst_q;
    lane_ctrl_t [`SFP_NLANES-1:0]    lane_ctrl_q;
    logic                            ack_q;
    logic [`SFP_DAT_W-1:0]           rdata_q;
    logic [`SFP_DAT_W-1:0]           status_word;
    logic                            lane_sel;
    logic                            access;

    assign lane_sel = req_i.adr[`SFP_LANE_BIT];

    // a held strobe is not taken again while its ack is out
    assign access = req_i.cyc && req_i.stb && !ack_q;

    // status word of the addressed lane
    always_comb begin
        status_word        = '0;
        status_word[0]     = gbe_rst_q;
        status_word[1]     = qpll_lock_i;
        status_word[2]     = lane_status_i[lane_sel].block_lock;
        status_word[3]     = lane_status_i[lane_sel].high_ber;
        status_word[4]     = lane_ctrl_q[lane_sel].eye_rst;
        status_word[10:8]  = lane_ctrl_q[lane_sel].loopback;
        status_word[31:16] = dmonitor_i[`SFP_DMON_W*lane_sel +: `SFP_DMON_W];
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            gbe_rst_q   <= 1'b0;
            lane_ctrl_q <= '0;
            ack_q       <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                // byte 0 holds the shared reset and the lane's eye-scan reset
                if (req_i.sel[0]) begin
                    gbe_rst_q                    <= req_i.dat[0];
                    lane_ctrl_q[lane_sel].eye_rst <= req_i.dat[4];
                end
                // byte 1 holds the loopback mode
                if (req_i.sel[1]) begin
                    lane_ctrl_q[lane_sel].loopback <= req_i.dat[8 +: 3];
                end
            end
        end
    end

    // read data captured on the same edge that raises ack
    always_ff @(posedge wb_clk_i) begin
        if (access && !req_i.we) begin
            rdata_q <= status_word;
        end
    end

    assign rsp_o       = '{ack: ack_q, dat: rdata_q};
    assign gbe_rst_o   = gbe_rst_q;
    assign lane_ctrl_o = lane_ctrl_q;

endmodule

// File: design/drp_bridge.sv
`timescale 1ns/1ps
`include "sfp_ctrl_config.svh"

module drp_bridge (
    input  logic                               wb_clk_i,
    input  logic                               reset_i,
    input  sfp_bus_pkg::wb_req_t               req_i,
    output sfp_bus_pkg::wb_rsp_t               rsp_o,
    output logic [`SFP_NLANES-1:0]             drp_en_o,
    output drp_pkg::drp_cmd_t                  drp_cmd_o,
    input  logic [`SFP_NLANES-1:0]             drp_rdy_i,
    input  logic [`SFP_NLANES*`DRP_DAT_W-1:0]  drp_do_i
);
    import drp_pkg::*;

    drp_state_e              state_q;
    drp_cmd_t                cmd_q;
    logic                    lane_q;
    logic [`SFP_NLANES-1:0]  drp_en_q;
    logic [`DRP_DAT_W-1:0]   rdata_q;
    logic                    strobe;
    logic                    start;
    logic                    done;

    assign strobe = req_i.cyc && req_i.stb;

    // only an idle bridge accepts a new access
    assign start = (state_q == DRP_IDLE) && strobe;

    // ready is only looked at on the lane that was enabled
    assign done = (state_q == DRP_WAIT) && drp_rdy_i[lane_q];

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q  <= DRP_IDLE;
            drp_en_q <= '0;
            lane_q   <= 1'b0;
        end else begin
            // enable is a single-cycle pulse
            drp_en_q <= '0;
            case (state_q)
                DRP_IDLE: begin
                    if (strobe) begin
                        lane_q                             <= req_i.adr[`DRP_LANE_BIT];
                        drp_en_q[req_i.adr[`DRP_LANE_BIT]] <= 1'b1;
                        state_q                            <= DRP_WAIT;
                    end
                end
                DRP_WAIT: begin
                    if (done) begin
                        state_q <= DRP_ACK;
                    end
                end
                DRP_ACK: begin
                    state_q <= DRP_IDLE;
                end
                default: begin
                    state_q <= DRP_IDLE;
                end
            endcase
        end
    end

    // command and read data
    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            cmd_q.we   <= req_i.we;
            cmd_q.addr <= req_i.adr[`DRP_ADR_LSB +: `DRP_ADR_W];
            cmd_q.di   <= req_i.dat[`DRP_DAT_W-1:0];
        end
        if (done) begin
            rdata_q <= drp_do_i[`DRP_DAT_W*lane_q +: `DRP_DAT_W];
        end
    end

    assign drp_en_o  = drp_en_q;
    assign drp_cmd_o = cmd_q;
    // upper half of the bus word reads as zero
    assign rsp_o     = '{ack: (state_q == DRP_ACK),
                         dat: {{(`SFP_DAT_W-`DRP_DAT_W){1'b0}}, rdata_q}};

endmodule

// File: design/sfp_ctrl_top.sv
`timescale 1ns/1ps
`include "sfp_ctrl_config.svh"

module sfp_ctrl_top (
    input  logic                                      wb_clk_i,
    input  logic                                      reset_i,
    input  sfp_bus_pkg::wb_req_t                      gtp_req_i,
    output sfp_bus_pkg::wb_rsp_t                      gtp_rsp_o,
    input  logic                                      qpll_lock_i,
    input  sfp_bus_pkg::lane_status_t [`SFP_NLANES-1:0] lane_status_i,
    input  logic [`SFP_NLANES*`SFP_DMON_W-1:0]        dmonitor_i,
    output logic                                      gbe_rst_o,
    output sfp_bus_pkg::lane_ctrl_t [`SFP_NLANES-1:0]   lane_ctrl_o,
    output logic [`SFP_NLANES-1:0]                    drp_en_o,
    output drp_pkg::drp_cmd_t                         drp_cmd_o,
    input  logic [`SFP_NLANES-1:0]                    drp_rdy_i,
    input  logic [`SFP_NLANES*`DRP_DAT_W-1:0]         drp_do_i
);
    import sfp_bus_pkg::*;

    logic                          drp_space;
    wb_req_t                       ctrl_req;
    wb_req_t                       drp_req;
    wb_rsp_t                       ctrl_rsp;
    wb_rsp_t                       drp_rsp;
    logic                          qpll_lock_s;
    lane_status_t [`SFP_NLANES-1:0] lane_status_s;

    // upper half of the address space goes to the DRP bridge
    assign drp_space = gtp_req_i.adr[`SFP_REGION_BIT];

    assign ctrl_req = '{cyc: gtp_req_i.cyc, stb: gtp_req_i.stb && !drp_space,
                        we: gtp_req_i.we, adr: gtp_req_i.adr,
                        sel: gtp_req_i.sel, dat: gtp_req_i.dat};

    assign drp_req = '{cyc: gtp_req_i.cyc, stb: gtp_req_i.stb && drp_space,
                       we: gtp_req_i.we, adr: gtp_req_i.adr,
                       sel: gtp_req_i.sel, dat: gtp_req_i.dat};

    // address is held through ack, so the region bit still picks the owner
    assign gtp_rsp_o = drp_space ? drp_rsp : ctrl_rsp;

    lane_status_sync u_sync (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .qpll_lock_i   (qpll_lock_i),
        .lane_status_i (lane_status_i),
        .qpll_lock_o   (qpll_lock_s),
        .lane_status_o (lane_status_s)
    );

    gt_ctrl_regs u_regs (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .req_i         (ctrl_req),
        .rsp_o         (ctrl_rsp),
        .qpll_lock_i   (qpll_lock_s),
        .lane_status_i (lane_status_s),
        .dmonitor_i    (dmonitor_i),
        .gbe_rst_o     (gbe_rst_o),
        .lane_ctrl_o   (lane_ctrl_o)
    );

    drp_bridge u_drp (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .req_i     (drp_req),
        .rsp_o     (drp_rsp),
        .drp_en_o  (drp_en_o),
        .drp_cmd_o (drp_cmd_o),
        .drp_rdy_i (drp_rdy_i),
        .drp_do_i  (drp_do_i)
    );

endmodule

// File: verif/drp_lane_model.sv
`timescale 1ns/1ps
`include "sfp_ctrl_config.svh"

module drp_lane_model (
    input  logic                  wb_clk_i,
    input  logic                  drp_en_i,
    input  drp_pkg::drp_cmd_t     drp_cmd_i,
    output logic                  drp_rdy_o,
    output logic [`DRP_DAT_W-1:0] drp_do_o
);
    logic [`DRP_DAT_W-1:0] mem [1 << `DRP_ADR_W];
    integer seed = 32'h7f08_317d;

    initial begin
        int delay;
        logic [`DRP_DAT_W-1:0] rdata;
        mem = '{default: '0};
        drp_rdy_o <= 1'b0;
        drp_do_o  <= '0;
        forever begin
            @(posedge wb_clk_i);
            if (drp_en_i) begin
                if (drp_cmd_i.we) begin
                    mem[drp_cmd_i.addr] = drp_cmd_i.di;
                end
                rdata = mem[drp_cmd_i.addr];
                // lane answers 1 to 4 cycles later
                delay = 1 + ({$random(seed)} % 4);
                repeat (delay) @(posedge wb_clk_i);
                drp_rdy_o <= 1'b1;
                drp_do_o  <= rdata;
                @(posedge wb_clk_i);
                drp_rdy_o <= 1'b0;
            end
        end
    end

endmodule

// File: verif/sfp_ctrl_tb.sv
`timescale 1ns/1ps
`include "sfp_ctrl_config.svh"

module sfp_ctrl_tb;
    import sfp_bus_pkg::*;
    import drp_pkg::*;

    localparam int ACK_TIMEOUT = 50;

    logic                               wb_clk_i;
    logic                               reset_i;
    wb_req_t                            gtp_req;
    wb_rsp_t                            gtp_rsp;
    logic                               qpll_lock;
    lane_status_t [`SFP_NLANES-1:0]     lane_status;
    logic [`SFP_NLANES*`SFP_DMON_W-1:0] dmonitor;
    logic                               gbe_rst;
    lane_ctrl_t [`SFP_NLANES-1:0]       lane_ctrl;
    logic [`SFP_NLANES-1:0]             drp_en;
    drp_cmd_t                           drp_cmd;
    logic [`SFP_NLANES-1:0]             drp_rdy;
    logic [`SFP_NLANES*`DRP_DAT_W-1:0]  drp_do;

    integer      seed = 32'h7f08_317d;
    int          errors = 0;
    int          checks = 0;
    int          hangs = 0;
    int          en_cnt0 = 0;
    int          en_cnt1 = 0;
    string       test_name;
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       cmp_name;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    // shadow copies of the control registers and of the lane DRP arrays
    logic                   sh_gbe_rst;
    logic [`SFP_NLANES-1:0] sh_eye;
    logic [2:0]             sh_loop [`SFP_NLANES];
    logic [`DRP_DAT_W-1:0]  sh_drp [`SFP_NLANES][1 << `DRP_ADR_W];

    sfp_ctrl_top dut0 (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .gtp_req_i     (gtp_req),
        .gtp_rsp_o     (gtp_rsp),
        .qpll_lock_i   (qpll_lock),
        .lane_status_i (lane_status),
        .dmonitor_i    (dmonitor),
        .gbe_rst_o     (gbe_rst),
        .lane_ctrl_o   (lane_ctrl),
        .drp_en_o      (drp_en),
        .drp_cmd_o     (drp_cmd),
        .drp_rdy_i     (drp_rdy),
        .drp_do_i      (drp_do)
    );

    for (genvar l = 0; l < `SFP_NLANES; l++) begin : g_lane
        drp_lane_model u_model (
            .wb_clk_i  (wb_clk_i),
            .drp_en_i  (drp_en[l]),
            .drp_cmd_i (drp_cmd),
            .drp_rdy_o (drp_rdy[l]),
            .drp_do_o  (drp_do[`DRP_DAT_W*l +: `DRP_DAT_W])
        );
    end

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    // enable pulses seen per lane
    always @(posedge wb_clk_i) begin
        if (drp_en[0]) begin
            en_cnt0++;
        end
        if (drp_en[1]) begin
            en_cnt1++;
        end
    end

    // compare process draining the queued checks on every edge
    always @(posedge wb_clk_i) begin
        while (act_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            checks++;
            assert (cmp_act === cmp_exp)
            else begin
                errors++;
                $display("Error: %s expected %h actual %h", cmp_name, cmp_exp, cmp_act);
            end
        end
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // status word layout of one lane
    function automatic logic [31:0] expected_status(input logic lane);
        logic [31:0] w;
        w        = '0;
        w[0]     = sh_gbe_rst;
        w[1]     = qpll_lock;
        w[2]     = lane_status[lane].block_lock;
        w[3]     = lane_status[lane].high_ber;
        w[4]     = sh_eye[lane];
        w[10:8]  = sh_loop[lane];
        w[31:16] = dmonitor[`SFP_DMON_W*lane +: `SFP_DMON_W];
        return w;
    endfunction

    function automatic logic [31:0] expected_ctrl_pins();
        return {23'd0, sh_gbe_rst, sh_eye[1], sh_loop[1], sh_eye[0], sh_loop[0]};
    endfunction

    task automatic queue_check(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        name_q.push_back({test_name, ": ", name});
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors, %0d hung accesses", checks, errors, hangs);
        if (errors == 0 && hangs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // one classic Wishbone access with stb held until ack is sampled
    task automatic bus_access(input string name, input logic we,
                              input logic [`SFP_ADR_W-1:0] adr, input logic [3:0] sel,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int          cycles;
        int          cnt0;
        int          cnt1;
        logic        seen;
        logic [31:0] exp_en;
        @(posedge wb_clk_i);
        gtp_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdat};
        cnt0 = en_cnt0;
        cnt1 = en_cnt1;
        // ack must still be low on the edge that samples stb
        @(posedge wb_clk_i);
        queue_check({name, " early ack"}, 32'd0, {31'd0, gtp_rsp.ack});
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge wb_clk_i);
            cycles++;
            if (gtp_rsp.ack === 1'b1) begin
                seen = 1'b1;
            end else if (cycles >= ACK_TIMEOUT) begin
                $display("%s %s hung with no ack for %0d cycles", test_name, name, cycles);
                hangs++;
                finish_run();
            end
        end
        rdat = gtp_rsp.dat;
        gtp_req <= '0;
        @(posedge wb_clk_i);
        queue_check({name, " second ack"}, 32'd0, {31'd0, gtp_rsp.ack});
        if (adr[`SFP_REGION_BIT]) begin
            exp_en = adr[`DRP_LANE_BIT] ? 32'h0001_0000 : 32'h0000_0001;
        end else begin
            exp_en = 32'd0;
            queue_check({name, " latency"}, 32'd1, cycles);
        end
        queue_check({name, " drp_en"}, exp_en, {16'(en_cnt1 - cnt1), 16'(en_cnt0 - cnt0)});
    endtask

    task automatic ctrl_access(input logic we, input logic lane, input logic [3:0] sel,
                               input logic [31:0] wdat);
        logic [`SFP_ADR_W-1:0] adr;
        logic [31:0]           rdat;
        adr = '0;
        adr[`SFP_LANE_BIT] = lane;
        bus_access(we ? "ctrl write" : "ctrl read", we, adr, sel, wdat, rdat);
        if (we) begin
            if (sel[0]) begin
                sh_gbe_rst   = wdat[0];
                sh_eye[lane] = wdat[4];
            end
            if (sel[1]) begin
                sh_loop[lane] = wdat[10:8];
            end
            queue_check("ctrl pins", expected_ctrl_pins(), {23'd0, gbe_rst, lane_ctrl});
        end else begin
            queue_check("status word", expected_status(lane), rdat);
        end
    endtask

    task automatic drp_access(input logic we, input logic lane,
                              input logic [`DRP_ADR_W-1:0] addr,
                              input logic [`DRP_DAT_W-1:0] wdat);
        logic [`SFP_ADR_W-1:0] adr;
        logic [31:0]           rdat;
        adr = '0;
        adr[`SFP_REGION_BIT] = 1'b1;
        adr[`DRP_LANE_BIT]   = lane;
        adr[`DRP_ADR_LSB +: `DRP_ADR_W] = addr;
        bus_access(we ? "drp write" : "drp read", we, adr, 4'hf, {16'd0, wdat}, rdat);
        if (we) begin
            sh_drp[lane][addr] = wdat;
        end else begin
            queue_check("drp data", {16'd0, sh_drp[lane][addr]}, rdat);
        end
    endtask

    initial begin
        logic [31:0]           r;
        logic [`DRP_ADR_W-1:0] addrs [16];
        logic                  lanes [16];
        reset_i     <= 1'b1;
        gtp_req     <= '0;
        qpll_lock   <= 1'b0;
        lane_status <= '0;
        dmonitor    <= '0;
        sh_gbe_rst = 1'b0;
        sh_eye     = '0;
        sh_loop    = '{default: '0};
        sh_drp     = '{default: '0};
        repeat (3) @(posedge wb_clk_i);
        reset_i <= 1'b0;

        test_name = "reset state";
        @(posedge wb_clk_i);
        queue_check("outputs", 32'd0, {21'd0, gbe_rst, lane_ctrl, drp_en});
        ctrl_access(1'b0, 1'b0, 4'h0, 32'd0);
        ctrl_access(1'b0, 1'b1, 4'h0, 32'd0);

        test_name = "control writes";
        repeat (24) begin
            r = next_random();
            ctrl_access(1'b1, r[0], r[7:4], next_random());
            ctrl_access(1'b0, r[1], 4'h0, 32'd0);
        end

        test_name = "status reflection";
        repeat (8) begin
            @(posedge wb_clk_i);
            r = next_random();
            qpll_lock   <= r[0];
            lane_status <= r[7:4];
            dmonitor    <= next_random();
            repeat (`SYNC_STAGES + 2) @(posedge wb_clk_i);
            ctrl_access(1'b0, 1'b0, 4'h0, 32'd0);
            ctrl_access(1'b0, 1'b1, 4'h0, 32'd0);
        end

        test_name = "drp round trip";
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            lanes[i] = r[0];
            addrs[i] = r[11:2];
            drp_access(1'b1, r[0], r[11:2], r[31:16]);
        end
        for (int i = 0; i < 16; i++) begin
            drp_access(1'b0, lanes[i], addrs[i], 16'd0);
        end

        test_name = "mixed sequence";
        repeat (40) begin
            r = next_random();
            case (r[1:0])
                2'd0: ctrl_access(1'b1, r[2], r[7:4], next_random());
                2'd1: ctrl_access(1'b0, r[2], 4'h0, 32'd0);
                2'd2: drp_access(1'b1, lanes[r[11:8]], addrs[r[11:8]], r[31:16]);
                default: drp_access(1'b0, lanes[r[11:8]], addrs[r[11:8]], 16'd0);
            endcase
        end

        repeat (2) @(posedge wb_clk_i);
        finish_run();
    end

endmodule

// File: project.f
+incdir+design
design/sfp_bus_pkg.sv
design/drp_pkg.sv
design/lane_status_sync.sv
design/gt_ctrl_regs.sv
design/drp_bridge.sv
design/sfp_ctrl_top.sv
verif/drp_lane_model.sv
verif/sfp_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module sfp_ctrl_tb -o sfp_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sfp_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
# the run passes only if the testbench printed its pass line
echo "$out" | grep -qx "PASS: all tests" || exit 1
exit 0
